/* design/viterbiTrellisPkg.sv */
`default_nettype none

package viterbiTrellisPkg;

   // --------------------
   // Trellis dimensions
   // --------------------
   localparam int NUM_STATES = 20;
   localparam int STATE_W    = 5;
   localparam int BRANCH_W   = 8;

   // Four bits of headroom over one branch part
   localparam int METRIC_W   = BRANCH_W + 4;

   // --------------------
   // Trellis connections
   // --------------------
   // Candidate 0 of state j comes from state j+13 over its branch 1
   localparam int PRED0_OFFSET = 13;
   // Candidate 1 of state j comes from state j+7 over its branch 0
   localparam int PRED1_OFFSET = 7;

   typedef logic [STATE_W-1:0] stateIndexT;

   typedef logic signed [METRIC_W-1:0] metricT;

   typedef metricT [NUM_STATES-1:0] metricVectorT;

   // Bit j set when candidate 1 won at state j
   typedef logic [NUM_STATES-1:0] selectVectorT;

   // Predecessor of a state on the given candidate, modulo the state count
   function automatic stateIndexT predState(input stateIndexT state, input logic cand);
      int offset;
      offset = cand ? PRED1_OFFSET : PRED0_OFFSET;
      return stateIndexT'((int'(state) + offset) % NUM_STATES);
   endfunction

endpackage

`default_nettype wire

/* design/viterbiIoPkg.sv */
`default_nettype none

package viterbiIoPkg;
   import viterbiTrellisPkg::*;

   // Real part feeds the metric, imaginary part the frequency error
   typedef struct packed {
      logic signed [BRANCH_W-1:0] re;
      logic signed [BRANCH_W-1:0] im;
   } branchPairT;

   typedef struct packed {
      branchPairT branch1;
      branchPairT branch0;
   } stateBranchesT;

   // One symbol, both branches of every state
   typedef stateBranchesT [NUM_STATES-1:0] symbolT;

   typedef struct packed {
      logic signed [BRANCH_W-1:0] freqError;
      stateIndexT                 bestState;
   } resultT;

endpackage

`default_nettype wire

/* design/symbolControl.sv */
`timescale 1ns/10ps
`default_nettype none

module symbolControl import viterbiTrellisPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic symReq,
   output logic symAck,
   output logic resReq,
   input  logic resAck,
   input  logic searchDone,
   output logic acsUpdate,
   output logic searchStart,
   output logic captureResult
);

   typedef enum logic [1:0] {
      stIdle,
      stSearch,
      stResultWait,
      stRelease
   } ctrlStateT;

   ctrlStateT state;

   // Accept a symbol as soon as it is offered in idle
   assign acsUpdate = (state == stIdle) && symReq;

   // --------------------
   // Sequence and handshakes
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= stIdle;
         symAck        <= 1'b0;
         resReq        <= 1'b0;
         searchStart   <= 1'b0;
         captureResult <= 1'b0;
      end else begin
         searchStart   <= 1'b0;
         captureResult <= 1'b0;
         case (state)
            stIdle: begin
               if (acsUpdate) begin
                  symAck      <= 1'b1;
                  searchStart <= 1'b1;
                  state       <= stSearch;
               end
            end
            stSearch: begin
               if (searchDone) begin
                  captureResult <= 1'b1;
                  state         <= stResultWait;
               end
            end
            stResultWait: begin
               // Request rises with the result load
               if (captureResult) begin
                  resReq <= 1'b1;
               end else if (resReq && resAck) begin
                  resReq <= 1'b0;
                  state  <= stRelease;
               end
            end
            stRelease: begin
               // Both sides back to rest before the next symbol
               if (!resAck && !symReq) begin
                  symAck <= 1'b0;
                  state  <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Result request rises exactly after the full search of the accepted symbol
   assert property (@(posedge clk) disable iff (reset)
      acsUpdate |-> !resReq [*NUM_STATES+3] ##1 resReq)
      else $error("resReq did not follow symbol accept at the expected cycle");

   // No second accept while the symbol is still in the search
   assert property (@(posedge clk) disable iff (reset)
      acsUpdate |=> !acsUpdate [*NUM_STATES+2])
      else $error("acsUpdate repeated before the search of the symbol ended");

endmodule

`default_nettype wire

/* design/acsArray.sv */
`timescale 1ns/10ps
`default_nettype none

module acsArray import viterbiTrellisPkg::*, viterbiIoPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         acsUpdate,
   input  symbolT       symbol,
   input  metricT       bestMetric,
   output metricVectorT survivorMetrics,
   output selectVectorT selects
);

   wire metricVectorT nextMetrics;
   wire selectVectorT nextSelects;

   // --------------------
   // One ACS per state
   // --------------------
   for (genvar j = 0; j < NUM_STATES; j++) begin : gAcs
      stateIndexT pred0;
      stateIndexT pred1;
      metricT     cand0;
      metricT     cand1;

      assign pred0 = predState(stateIndexT'(j), 1'b0);
      assign pred1 = predState(stateIndexT'(j), 1'b1);

      // Add branch real part, normalize by the previous best
      assign cand0 = survivorMetrics[pred0] + metricT'(symbol[pred0].branch1.re)
                     - bestMetric;
      assign cand1 = survivorMetrics[pred1] + metricT'(symbol[pred1].branch0.re)
                     - bestMetric;

      // Compare and select, tie keeps candidate 0
      assign nextSelects[j] = cand1 > cand0;
      assign nextMetrics[j] = nextSelects[j] ? cand1 : cand0;

      // Normalized metric never climbs above two full-scale branch magnitudes
      assert property (@(posedge clk) disable iff (reset)
         acsUpdate |=> $signed(survivorMetrics[j]) <= 2 ** BRANCH_W)
         else $error("survivor metric of state %0d out of range", j);
   end

   // --------------------
   // Survivor registers
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         survivorMetrics <= '0;
         selects         <= '0;
      end else if (acsUpdate) begin
         survivorMetrics <= nextMetrics;
         selects         <= nextSelects;
      end
   end

endmodule

`default_nettype wire

/* design/bestStateSearch.sv */
`timescale 1ns/10ps
`default_nettype none

module bestStateSearch import viterbiTrellisPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         searchStart,
   input  metricVectorT survivorMetrics,
   output logic         searchDone,
   output stateIndexT   bestState,
   output metricT       bestMetric
);

   logic       scanning;
   stateIndexT scanIdx;
   metricT     scanMetric;

   assign scanMetric = survivorMetrics[scanIdx];

   // --------------------
   // Sequential max scan
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         scanning   <= 1'b0;
         scanIdx    <= '0;
         searchDone <= 1'b0;
         bestState  <= '0;
         bestMetric <= '0;
      end else begin
         searchDone <= 1'b0;
         if (searchStart) begin
            // State 0 seeds the running maximum
            scanning   <= 1'b1;
            scanIdx    <= stateIndexT'(1);
            bestState  <= '0;
            bestMetric <= survivorMetrics[0];
         end else if (scanning) begin
            // Strictly larger only, so the lower index wins a tie
            if (scanMetric > bestMetric) begin
               bestState  <= scanIdx;
               bestMetric <= scanMetric;
            end
            if (scanIdx == stateIndexT'(NUM_STATES - 1)) begin
               scanning   <= 1'b0;
               scanIdx    <= '0;
               searchDone <= 1'b1;
            end else begin
               scanIdx <= scanIdx + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* design/freqErrorSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module freqErrorSelect import viterbiTrellisPkg::*, viterbiIoPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         acsUpdate,
   input  logic         captureResult,
   input  symbolT       symbol,
   input  selectVectorT selects,
   input  stateIndexT   bestState,
   output resultT       result
);

   // Imaginary parts of the accepted symbol
   logic signed [BRANCH_W-1:0] imag0 [NUM_STATES];
   logic signed [BRANCH_W-1:0] imag1 [NUM_STATES];

   logic                       winSel;
   stateIndexT                 winPred;
   logic signed [BRANCH_W-1:0] freqErrorNext;

   always_ff @(posedge clk) begin
      if (acsUpdate) begin
         for (int s = 0; s < NUM_STATES; s++) begin
            imag0[s] <= symbol[s].branch0.im;
            imag1[s] <= symbol[s].branch1.im;
         end
      end
   end

   // Winning branch into the best state
   assign winSel        = selects[bestState];
   assign winPred       = predState(bestState, winSel);
   assign freqErrorNext = winSel ? imag0[winPred] : imag1[winPred];

   always_ff @(posedge clk) begin
      if (reset) begin
         result <= '0;
      end else if (captureResult) begin
         result.freqError <= freqErrorNext;
         result.bestState <= bestState;
      end
   end

endmodule

`default_nettype wire

/* design/viterbiTop.sv */
`timescale 1ns/10ps
`default_nettype none

module viterbiTop import viterbiTrellisPkg::*, viterbiIoPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  symbolT symbol,
   input  logic   symReq,
   output logic   symAck,
   output resultT result,
   output logic   resReq,
   input  logic   resAck
);

   // Control pulses
   logic acsUpdate;
   logic searchStart;
   logic searchDone;
   logic captureResult;

   // Datapath
   metricVectorT survivorMetrics;
   selectVectorT selects;
   stateIndexT   bestState;
   metricT       bestMetric;

   symbolControl symbolControl_i (
      .clk           (clk),
      .reset         (reset),
      .symReq        (symReq),
      .symAck        (symAck),
      .resReq        (resReq),
      .resAck        (resAck),
      .searchDone    (searchDone),
      .acsUpdate     (acsUpdate),
      .searchStart   (searchStart),
      .captureResult (captureResult)
   );

   acsArray acsArray_i (
      .clk             (clk),
      .reset           (reset),
      .acsUpdate       (acsUpdate),
      .symbol          (symbol),
      .bestMetric      (bestMetric),
      .survivorMetrics (survivorMetrics),
      .selects         (selects)
   );

   bestStateSearch bestStateSearch_i (
      .clk             (clk),
      .reset           (reset),
      .searchStart     (searchStart),
      .survivorMetrics (survivorMetrics),
      .searchDone      (searchDone),
      .bestState       (bestState),
      .bestMetric      (bestMetric)
   );

   freqErrorSelect freqErrorSelect_i (
      .clk           (clk),
      .reset         (reset),
      .acsUpdate     (acsUpdate),
      .captureResult (captureResult),
      .symbol        (symbol),
      .selects       (selects),
      .bestState     (bestState),
      .result        (result)
   );

endmodule

`default_nettype wire

/* verification/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
   output logic clk,
   output logic reset
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // Reset held over the first 16 rising edges, released on a falling edge
   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

/* verification/viterbiTb.sv */
`timescale 1ns/10ps
`default_nettype none

module viterbiTb import viterbiTrellisPkg::*, viterbiIoPkg::*; ();

   localparam int TIMEOUT_CYCLES = 200;

   logic   clk;
   logic   reset;
   symbolT symbol;
   logic   symReq;
   logic   symAck;
   resultT result;
   logic   resReq;
   logic   resAck;

   // Reference trellis state
   resultT expResult;
   int     modelMetrics [NUM_STATES];
   int     modelBest;

   int     errorCount;
   int     symbolCount;
   bit     aborted;

   // Handshake bookkeeping
   logic   symAckQ;
   logic   resAckQ;
   int     accepted;
   int     completed;

   clockGen clockGen_i (
      .clk   (clk),
      .reset (reset)
   );

   viterbiTop viterbiTop_i (
      .clk    (clk),
      .reset  (reset),
      .symbol (symbol),
      .symReq (symReq),
      .symAck (symAck),
      .result (result),
      .resReq (resReq),
      .resAck (resAck)
   );

   task automatic reportViolation(input string what);
      errorCount++;
      $display("Handshake problem at %0d ns: %s", $time, what);
   endtask

   // --------------------
   // Checks
   // --------------------
   // Counts accepted symbols and finished result handshakes
   always @(posedge clk) begin
      if (reset) begin
         symAckQ   <= 1'b0;
         resAckQ   <= 1'b0;
         accepted  <= 0;
         completed <= 0;
      end else begin
         symAckQ <= symAck;
         resAckQ <= resAck;
         if (symAck && !symAckQ) begin
            accepted <= accepted + 1;
         end
         if (!resAck && resAckQ) begin
            completed <= completed + 1;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) $rose(resReq) |-> result == expResult)
      else begin
         errorCount++;
         $display("error at %0d ns: got state %0d freq %0d, expected state %0d freq %0d",
                  $time, result.bestState, result.freqError, expResult.bestState,
                  expResult.freqError);
      end

   assert property (@(posedge clk) disable iff (reset) $rose(symAck) |-> $past(symReq))
      else reportViolation("symAck rose although no symbol was requested");
   assert property (@(posedge clk) disable iff (reset) $fell(symAck) |-> $past(!symReq))
      else reportViolation("symAck fell while symReq was still high");
   assert property (@(posedge clk) disable iff (reset) $rose(resReq) |-> $past(!resAck))
      else reportViolation("resReq rose while resAck was still high");
   assert property (@(posedge clk) disable iff (reset) $fell(resReq) |-> $past(resAck))
      else reportViolation("resReq fell before the sink acknowledged");
   assert property (@(posedge clk) disable iff (reset) resReq && $past(resReq) |-> $stable(result))
      else reportViolation("result changed while resReq was high");
   assert property (@(posedge clk) disable iff (reset) resReq |-> symAck)
      else reportViolation("symAck dropped before the result was taken");
   assert property (@(posedge clk) disable iff (reset) $fell(symAck) |-> accepted == completed)
      else reportViolation("symAck dropped before the result handshake completed");

   // --------------------
   // Reference model
   // --------------------
   function automatic int wrapMetric(input int value);
      logic signed [METRIC_W-1:0] narrow;
      narrow = value[METRIC_W-1:0];
      return int'(narrow);
   endfunction

   // Steps the trellis by one symbol and sets the expected result
   task automatic predictResult(input symbolT s);
      int nextMetrics [NUM_STATES];
      bit sel [NUM_STATES];
      int p0;
      int p1;
      int cand0;
      int cand1;
      int bestIdx;
      for (int j = 0; j < NUM_STATES; j++) begin
         p0 = (j + PRED0_OFFSET) % NUM_STATES;
         p1 = (j + PRED1_OFFSET) % NUM_STATES;
         cand0 = wrapMetric(modelMetrics[p0] + int'(s[p0].branch1.re) - modelBest);
         cand1 = wrapMetric(modelMetrics[p1] + int'(s[p1].branch0.re) - modelBest);
         sel[j] = cand1 > cand0;
         nextMetrics[j] = sel[j] ? cand1 : cand0;
      end
      bestIdx = 0;
      for (int j = 1; j < NUM_STATES; j++) begin
         if (nextMetrics[j] > nextMetrics[bestIdx]) begin
            bestIdx = j;
         end
      end
      modelMetrics = nextMetrics;
      modelBest = nextMetrics[bestIdx];
      expResult.bestState = stateIndexT'(bestIdx);
      if (sel[bestIdx]) begin
         expResult.freqError = s[(bestIdx + PRED1_OFFSET) % NUM_STATES].branch0.im;
      end else begin
         expResult.freqError = s[(bestIdx + PRED0_OFFSET) % NUM_STATES].branch1.im;
      end
   endtask

   function automatic bit metricsLevel();
      for (int j = 1; j < NUM_STATES; j++) begin
         if (modelMetrics[j] != modelMetrics[0]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   function automatic symbolT randomSymbol();
      symbolT s;
      for (int j = 0; j < NUM_STATES; j++) begin
         s[j] = stateBranchesT'($urandom);
      end
      return s;
   endfunction

   // --------------------
   // Handshake drivers
   // --------------------
   task automatic waitForLevel(input bit onResReq, input logic level, input string what);
      int cycles;
      cycles = 0;
      if (aborted) begin
         return;
      end
      while ((onResReq ? resReq : symAck) !== level && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if ((onResReq ? resReq : symAck) !== level) begin
         aborted = 1'b1;
         $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
      end
   endtask

   // Full symbol and result handshake with resAck held back by ackDelay cycles
   task automatic exchangeSymbol(input symbolT s, input int ackDelay);
      if (aborted) begin
         return;
      end
      @(negedge clk);
      symbol = s;
      symReq = 1'b1;
      waitForLevel(1'b0, 1'b1, "symAck to rise");
      symReq = 1'b0;
      waitForLevel(1'b1, 1'b1, "resReq to rise");
      repeat (ackDelay) @(negedge clk);
      resAck = 1'b1;
      waitForLevel(1'b1, 1'b0, "resReq to fall");
      resAck = 1'b0;
      waitForLevel(1'b0, 1'b0, "symAck to fall");
      symbolCount++;
   endtask

   task automatic reportTest(input string name, input int firstSymbol, input int firstError);
      $display("%s: %0d symbols, %0d errors", name, symbolCount - firstSymbol,
               errorCount - firstError);
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      symbolT s;
      int     k;
      int     gap;
      int     passes;
      int     cycles;
      int     firstSymbol;
      int     firstError;

      symbol       = '0;
      symReq       = 1'b0;
      resAck       = 1'b0;
      expResult    = '0;
      modelMetrics = '{default: 0};
      modelBest    = 0;
      errorCount   = 0;
      symbolCount  = 0;
      aborted      = 1'b0;
      void'($urandom(32379));

      cycles = 0;
      @(negedge clk);
      while (reset && cycles < 40) begin
         @(negedge clk);
         cycles++;
      end
      if (reset) begin
         aborted = 1'b1;
         $display("Reset was never released");
      end

      // Single large branch 1 real part on metrics cleared by reset
      firstSymbol = symbolCount;
      firstError  = errorCount;
      assert (!symAck && !resReq)
         else reportViolation("symAck or resReq high after reset");
      k = $urandom_range(NUM_STATES - 1);
      s = randomSymbol();
      for (int j = 0; j < NUM_STATES; j++) begin
         s[j].branch0.re = '0;
         s[j].branch1.re = '0;
      end
      s[k].branch1.re = 8'sd100;
      predictResult(s);
      // Winner is the candidate 0 successor of state k
      expResult.bestState = stateIndexT'((k + NUM_STATES - PRED0_OFFSET) % NUM_STATES);
      expResult.freqError = s[k].branch1.im;
      exchangeSymbol(s, 0);
      reportTest("single branch after reset", firstSymbol, firstError);

      firstSymbol = symbolCount;
      firstError  = errorCount;
      for (int n = 0; n < 200 && !aborted; n++) begin
         s = randomSymbol();
         predictResult(s);
         exchangeSymbol(s, 0);
      end
      reportTest("random symbols", firstSymbol, firstError);

      // Without normalization these would overflow the metric width
      firstSymbol = symbolCount;
      firstError  = errorCount;
      for (int n = 0; n < 100 && !aborted; n++) begin
         s = randomSymbol();
         for (int j = 0; j < NUM_STATES; j++) begin
            s[j].branch0.re = 8'sd127;
            s[j].branch1.re = 8'sd127;
         end
         predictResult(s);
         exchangeSymbol(s, 0);
      end
      reportTest("full-scale branches", firstSymbol, firstError);

      // Bring all metrics to one level before all real parts go equal
      firstSymbol = symbolCount;
      firstError  = errorCount;
      passes = 0;
      while (!metricsLevel() && passes < 40 && !aborted) begin
         s = randomSymbol();
         for (int j = 0; j < NUM_STATES; j++) begin
            gap = modelBest - modelMetrics[j];
            if (gap > 127) begin
               gap = 127;
            end
            s[j].branch0.re = gap[BRANCH_W-1:0];
            s[j].branch1.re = gap[BRANCH_W-1:0];
         end
         predictResult(s);
         exchangeSymbol(s, 0);
         passes++;
      end
      if (!metricsLevel()) begin
         errorCount++;
         $display("Metrics could not be levelled for the tie test");
      end
      for (int n = 0; n < 10 && !aborted; n++) begin
         s = randomSymbol();
         for (int j = 1; j < NUM_STATES; j++) begin
            s[j].branch0.re = s[0].branch0.re;
            s[j].branch1.re = s[0].branch0.re;
         end
         s[0].branch1.re = s[0].branch0.re;
         predictResult(s);
         // Tie goes to state 0 over candidate 0
         expResult.bestState = '0;
         expResult.freqError = s[PRED0_OFFSET].branch1.im;
         exchangeSymbol(s, 0);
      end
      reportTest("equal branches", firstSymbol, firstError);

      firstSymbol = symbolCount;
      firstError  = errorCount;
      for (int n = 0; n < 50 && !aborted; n++) begin
         s = randomSymbol();
         predictResult(s);
         exchangeSymbol(s, $urandom_range(30));
      end
      reportTest("delayed result ack", firstSymbol, firstError);

      $display("Totals: %0d symbols, %0d errors", symbolCount, errorCount);
      if (aborted || errorCount != 0) begin
         $display("Simulation finished: FAIL");
      end else begin
         $display("Simulation finished: PASS");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
design/viterbiTrellisPkg.sv
design/viterbiIoPkg.sv
design/symbolControl.sv
design/acsArray.sv
design/bestStateSearch.sv
design/freqErrorSelect.sv
design/viterbiTop.sv
verification/clockGen.sv
verification/viterbiTb.sv
